// File: hdl/board_pkg.sv
// board geometry constants and the cell, index, entry, mask and board types
`default_nettype none

package board_pkg;

   // ------------------------------------------------
   // geometry
   // ------------------------------------------------
   localparam int board_dim = 4;
   localparam int num_cells = board_dim * board_dim;
   localparam int cell_w    = 3;

   // ------------------------------------------------
   // vector types
   // ------------------------------------------------
   // 0 is an empty cell, 1 to 4 are the symbols
   typedef logic [cell_w-1:0] cell_t;

   // row * board_dim + column
   typedef logic [$clog2(num_cells)-1:0] cell_idx_t;

   // player value 0..3, stored on the board as value + 1
   typedef logic [1:0] entry_t;

   // one bit per cell
   typedef logic [num_cells-1:0] mask_t;

   // cell i sits in bits [i*cell_w +: cell_w]
   typedef logic [num_cells*cell_w-1:0] board_t;

endpackage

`default_nettype wire

// File: hdl/level_pkg.sv
// difficulty levels and the random nibble type
`default_nettype none

package level_pkg;

   // number of hints shrinks from easy to hard
   typedef enum logic [1:0] {
      lvl_none   = 2'd0,
      lvl_easy   = 2'd1,
      lvl_medium = 2'd2,
      lvl_hard   = 2'd3
   } level_t;

   // one random nibble from the game controller
   typedef logic [3:0] rand_t;

endpackage

`default_nettype wire

// File: hdl/solution_key.sv
// key symbol register and its expansion into the solution board
`default_nettype none

module solution_key (
   input  wire                clka,
   input  wire                rst,
   input  wire                restart,
   input  wire                win_flag,
   input  wire                set_board_flag,
   input  level_pkg::rand_t   rand_a,
   input  level_pkg::rand_t   rand_b,
   output board_pkg::board_t  real_board
);

   import board_pkg::*;

   cell_t key_a;
   cell_t key_b;
   logic  key_valid;

   cell_t a_next;
   cell_t b_next;
   cell_t inv_a;
   cell_t inv_b;
   cell_t layout [num_cells];

   // ------------------------------------------------
   // key selection
   // ------------------------------------------------
   // a and b always come from different complement pairs
   always_comb begin
      if (!rand_a[1]) begin
         a_next = rand_a[0] ? cell_t'(4) : cell_t'(1);
         b_next = rand_b[0] ? cell_t'(3) : cell_t'(2);
      end else begin
         a_next = rand_a[0] ? cell_t'(3) : cell_t'(2);
         b_next = rand_b[0] ? cell_t'(4) : cell_t'(1);
      end
   end

   always_ff @(posedge clka) begin
      if (rst || restart || win_flag) begin
         key_a     <= '0;
         key_b     <= '0;
         key_valid <= 1'b0;
      end else if (set_board_flag) begin
         key_a     <= a_next;
         key_b     <= b_next;
         key_valid <= 1'b1;
      end
   end

   // ------------------------------------------------
   // fixed latin square layout
   // ------------------------------------------------
   assign inv_a = cell_t'(5) - key_a;
   assign inv_b = cell_t'(5) - key_b;

   always_comb begin
      // row 0
      layout[0]  = key_a;
      layout[1]  = inv_b;
      layout[2]  = key_b;
      layout[3]  = inv_a;
      // row 1
      layout[4]  = key_b;
      layout[5]  = inv_a;
      layout[6]  = key_a;
      layout[7]  = inv_b;
      // row 2
      layout[8]  = inv_b;
      layout[9]  = key_a;
      layout[10] = inv_a;
      layout[11] = key_b;
      // row 3
      layout[12] = inv_a;
      layout[13] = key_b;
      layout[14] = inv_b;
      layout[15] = key_a;
   end

   // empty board until a key has been loaded
   always_comb begin
      for (int i = 0; i < num_cells; i++) begin
         real_board[i*cell_w +: cell_w] = key_valid ? layout[i] : cell_t'(0);
      end
   end

endmodule

`default_nettype wire

// File: hdl/hint_select.sv
// decode of the random nibbles and the difficulty into the hint mask
`default_nettype none

module hint_select (
   input  level_pkg::rand_t   rand_a,
   input  level_pkg::rand_t   rand_b,
   input  level_pkg::level_t  difficulty,
   output board_pkg::mask_t   hint_mask
);

   import board_pkg::*;
   import level_pkg::*;

   logic [1:0]           field [board_dim];
   logic [board_dim-1:0] use_pair;

   // one cell per row, or two mirrored cells per row
   function automatic logic [board_dim-1:0] row_hint(input logic [1:0] sel,
                                                     input logic       pair);
      logic [board_dim-1:0] bits;
      if (pair) begin
         // outer columns for 0 and 3, inner columns for 1 and 2
         if (sel == 2'd0 || sel == 2'd3) begin
            bits = 4'b1001;
         end else begin
            bits = 4'b0110;
         end
      end else begin
         bits = 4'b0001 << sel;
      end
      return bits;
   endfunction

   // ------------------------------------------------
   // per-row fields and pair rule
   // ------------------------------------------------
   assign field[0] = rand_a[1:0];
   assign field[1] = rand_a[3:2];
   assign field[2] = rand_b[1:0];
   assign field[3] = rand_b[3:2];

   // row 2 pairs from medium down, row 1 pairs on easy only
   assign use_pair[0] = 1'b0;
   assign use_pair[1] = (difficulty == lvl_easy);
   assign use_pair[2] = (difficulty == lvl_easy) || (difficulty == lvl_medium);
   assign use_pair[3] = 1'b0;

   always_comb begin
      hint_mask = '0;
      if (difficulty != lvl_none) begin
         for (int r = 0; r < board_dim; r++) begin
            hint_mask[r*board_dim +: board_dim] = row_hint(field[r], use_pair[r]);
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/player_board.sv
// player cells, given-cell flags and solved flag under the command strobes
`default_nettype none

module player_board (
   input  wire                   clka,
   input  wire                   rst,
   input  wire                   restart,
   input  wire                   win_flag,
   input  wire                   set_board_flag,
   input  wire                   set_diff_flag,
   input  wire                   insert_flag,
   input  wire                   check_flag,
   input  wire                   try_again_flag,
   input  board_pkg::cell_idx_t  cell_in,
   input  board_pkg::entry_t     val_in,
   input  board_pkg::board_t     real_board,
   input  board_pkg::mask_t      hint_mask,
   output board_pkg::board_t     user_board,
   output board_pkg::mask_t      fill_flag,
   output logic                  solved
);

   import board_pkg::*;

   board_t user_next;
   mask_t  fill_next;
   logic   solved_next;
   logic   clear;

   assign clear = rst || restart || win_flag;

   // ------------------------------------------------
   // command decode, highest priority first
   // ------------------------------------------------
   always_comb begin
      user_next   = user_board;
      fill_next   = fill_flag;
      solved_next = solved;

      if (set_board_flag) begin
         // new key is loading, player state holds this cycle
      end else if (set_diff_flag) begin
         // givens copied from the solution and locked
         for (int i = 0; i < num_cells; i++) begin
            if (hint_mask[i]) begin
               user_next[i*cell_w +: cell_w] = real_board[i*cell_w +: cell_w];
            end
         end
         fill_next = fill_flag | hint_mask;
      end else if (insert_flag) begin
         // given cells cannot be overwritten
         if (!fill_flag[cell_in]) begin
            user_next[cell_in*cell_w +: cell_w] = cell_t'(val_in) + cell_t'(1);
         end
      end else if (check_flag) begin
         solved_next = (user_board == real_board);
      end else if (try_again_flag) begin
         // wipe the player's own entries only
         for (int i = 0; i < num_cells; i++) begin
            if (!fill_flag[i]) begin
               user_next[i*cell_w +: cell_w] = '0;
            end
         end
      end
   end

   // ------------------------------------------------
   // state registers
   // ------------------------------------------------
   always_ff @(posedge clka) begin
      if (clear) begin
         user_board <= '0;
         fill_flag  <= '0;
         solved     <= 1'b0;
      end else begin
         user_board <= user_next;
         fill_flag  <= fill_next;
         solved     <= solved_next;
      end
   end

endmodule

`default_nettype wire

// File: hdl/sudoku_top.sv
// sudoku datapath top joining the key, hint and player board blocks
`default_nettype none

module sudoku_top (
   input  wire                   clka,
   input  wire                   rst,
   input  wire                   restart,
   input  wire                   win_flag,
   input  wire                   set_board_flag,
   input  wire                   set_diff_flag,
   input  wire                   insert_flag,
   input  wire                   check_flag,
   input  wire                   try_again_flag,
   input  level_pkg::rand_t      rand_a,
   input  level_pkg::rand_t      rand_b,
   input  level_pkg::level_t     difficulty,
   input  board_pkg::cell_idx_t  cell_in,
   input  board_pkg::entry_t     val_in,
   output board_pkg::board_t     user_board,
   output board_pkg::board_t     real_board,
   output board_pkg::mask_t      fill_flag,
   output logic                  solved
);

   import board_pkg::*;

   // cells revealed by the current difficulty
   mask_t hint_mask;

   solution_key u_solution_key (
      .clka           (clka),
      .rst            (rst),
      .restart        (restart),
      .win_flag       (win_flag),
      .set_board_flag (set_board_flag),
      .rand_a         (rand_a),
      .rand_b         (rand_b),
      .real_board     (real_board)
   );

   hint_select u_hint_select (
      .rand_a     (rand_a),
      .rand_b     (rand_b),
      .difficulty (difficulty),
      .hint_mask  (hint_mask)
   );

   player_board u_player_board (
      .clka           (clka),
      .rst            (rst),
      .restart        (restart),
      .win_flag       (win_flag),
      .set_board_flag (set_board_flag),
      .set_diff_flag  (set_diff_flag),
      .insert_flag    (insert_flag),
      .check_flag     (check_flag),
      .try_again_flag (try_again_flag),
      .cell_in        (cell_in),
      .val_in         (val_in),
      .real_board     (real_board),
      .hint_mask      (hint_mask),
      .user_board     (user_board),
      .fill_flag      (fill_flag),
      .solved         (solved)
   );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// free-running clock source for the testbench
`default_nettype none

module tb_clock (
   output logic clka
);
   timeunit 1ns;
   timeprecision 100ps;

   // 40 ns period
   localparam int half_period = 20;

   initial begin
      clka = 1'b0;
   end

   always begin
      #half_period;
      clka = ~clka;
   end

endmodule

`default_nettype wire

// File: tb/sudoku_checker.sv
// concurrent assertions on the sudoku top-level outputs
`default_nettype none

module sudoku_checker (
   input wire                clka,
   input wire                rst,
   input wire                restart,
   input wire                win_flag,
   input wire                check_flag,
   input board_pkg::board_t  user_board,
   input board_pkg::board_t  real_board,
   input board_pkg::mask_t   fill_flag,
   input wire                solved
);
   timeunit 1ns;
   timeprecision 100ps;

   import board_pkg::*;

   logic clear;

   assign clear = rst || restart || win_flag;

   // every given cell holds its solution symbol
   function automatic logic givens_match(input board_t usr, input board_t sol, input mask_t flg);
      logic ok;
      ok = 1'b1;
      for (int i = 0; i < num_cells; i++) begin
         if (flg[i] && (usr[i*cell_w +: cell_w] != sol[i*cell_w +: cell_w])) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   // --------------------------------------------------
   // output invariants
   // --------------------------------------------------
   fill_kept: assert property (@(posedge clka)
      !clear |=> ((fill_flag & $past(fill_flag)) == $past(fill_flag)))
      else $error("fill_flag lost a bit without a clear");

   solved_held: assert property (@(posedge clka)
      !(clear || check_flag) |=> $stable(solved))
      else $error("solved changed without a clear or a check");

   givens_ok: assert property (@(posedge clka) disable iff (rst)
      givens_match(user_board, real_board, fill_flag))
      else $error("a given cell differs from the solution board");

   clear_zero: assert property (@(posedge clka)
      clear |=> (user_board == '0 && real_board == '0 && fill_flag == '0 && !solved))
      else $error("outputs not zero after a clear");

endmodule

`default_nettype wire

// File: tb/tb_sudoku.sv
// testbench for sudoku_top with random stimulus, reference model and compare tasks
`default_nettype none

module tb_sudoku;
   timeunit 1ns;
   timeprecision 100ps;

   import board_pkg::*;
   import level_pkg::*;

   localparam int drive_delay  = 2;
   localparam int edge_timeout = 100;
   localparam int run_limit_ns = 2000000;
   // layout as picks from a, b, 5-a, 5-b, row by row
   localparam int layout_pick [num_cells] = '{0, 3, 1, 2, 1, 2, 0, 3,
                                              3, 0, 2, 1, 2, 1, 3, 0};

   logic      clka;
   logic      rst;
   logic      restart;
   logic      win_flag;
   logic      set_board_flag;
   logic      set_diff_flag;
   logic      insert_flag;
   logic      check_flag;
   logic      try_again_flag;
   rand_t     rand_a;
   rand_t     rand_b;
   level_t    difficulty;
   cell_idx_t cell_in;
   entry_t    val_in;
   board_t    user_board;
   board_t    real_board;
   mask_t     fill_flag;
   logic      solved;

   // reference model state
   board_t m_real;
   board_t m_user;
   mask_t  m_fill;
   logic   m_solved;
   rand_t  key_ra;
   rand_t  key_rb;
   logic   key_loaded;
   int     edge_count = 0;
   int     edge_time = 0;

   tb_clock u_clock (.clka(clka));

   sudoku_top uut (
      .clka(clka), .rst(rst), .restart(restart), .win_flag(win_flag),
      .set_board_flag(set_board_flag), .set_diff_flag(set_diff_flag),
      .insert_flag(insert_flag), .check_flag(check_flag),
      .try_again_flag(try_again_flag), .rand_a(rand_a), .rand_b(rand_b),
      .difficulty(difficulty), .cell_in(cell_in), .val_in(val_in),
      .user_board(user_board), .real_board(real_board),
      .fill_flag(fill_flag), .solved(solved)
   );

   bind sudoku_top sudoku_checker u_checker (
      .clka(clka), .rst(rst), .restart(restart), .win_flag(win_flag),
      .check_flag(check_flag), .user_board(user_board),
      .real_board(real_board), .fill_flag(fill_flag), .solved(solved)
   );

   always @(posedge clka) begin
      edge_count = edge_count + 1;
      edge_time  = int'($time);
   end

   task automatic stop_failed();
      $display("** FAIL **");
      $fatal(1, "run stopped at the first error");
   endtask

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic check_board(input string name, input board_t got, input board_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_mask(input string name, input mask_t got, input mask_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         stop_failed();
      end
   endtask

   // next rising edge, then on to the drive point
   task automatic next_cycle();
      int start;
      int waited;
      start  = edge_count;
      waited = 0;
      while (edge_count == start && waited < edge_timeout) begin
         #1;
         waited++;
      end
      if (edge_count == start) begin
         $display("no clock edge arrived within %0d ns", edge_timeout);
         stop_failed();
      end else begin
         #(edge_time + drive_delay - int'($time));
      end
   endtask

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   function automatic board_t expected_real(input rand_t ra, input rand_t rb);
      cell_t  sym [4];
      board_t brd;
      if (ra[1] == 1'b0) begin
         sym[0] = ra[0] ? 3'd4 : 3'd1;
         sym[1] = rb[0] ? 3'd3 : 3'd2;
      end else begin
         sym[0] = ra[0] ? 3'd3 : 3'd2;
         sym[1] = rb[0] ? 3'd4 : 3'd1;
      end
      sym[2] = 3'd5 - sym[0];
      sym[3] = 3'd5 - sym[1];
      for (int i = 0; i < num_cells; i++) begin
         brd[i*cell_w +: cell_w] = sym[layout_pick[i]];
      end
      return brd;
   endfunction

   function automatic mask_t expected_hints(input rand_t ra, input rand_t rb, input level_t lvl);
      logic [1:0] f [4];
      mask_t      m;
      f[0] = ra[1:0];
      f[1] = ra[3:2];
      f[2] = rb[1:0];
      f[3] = rb[3:2];
      m = '0;
      if (lvl != lvl_none) begin
         for (int r = 0; r < 4; r++) begin
            m[4*r + int'(f[r])] = 1'b1;
         end
      end
      // pair rule replaces the single hint of row 2, and of row 1 on easy
      if (lvl == lvl_medium || lvl == lvl_easy) begin
         m[11:8] = (f[2] == 2'd0 || f[2] == 2'd3) ? 4'b1001 : 4'b0110;
      end
      if (lvl == lvl_easy) begin
         m[7:4] = (f[1] == 2'd0 || f[1] == 2'd3) ? 4'b1001 : 4'b0110;
      end
      return m;
   endfunction

   task automatic update_model();
      mask_t hm;
      if (rst || restart || win_flag) begin
         m_real     = '0;
         m_user     = '0;
         m_fill     = '0;
         m_solved   = 1'b0;
         key_loaded = 1'b0;
      end else if (set_board_flag) begin
         m_real     = expected_real(rand_a, rand_b);
         key_ra     = rand_a;
         key_rb     = rand_b;
         key_loaded = 1'b1;
      end else if (set_diff_flag) begin
         hm = expected_hints(rand_a, rand_b, difficulty);
         for (int i = 0; i < num_cells; i++) begin
            if (hm[i]) begin
               m_user[i*cell_w +: cell_w] = m_real[i*cell_w +: cell_w];
            end
         end
         m_fill = m_fill | hm;
      end else if (insert_flag) begin
         if (!m_fill[cell_in]) begin
            m_user[int'(cell_in)*cell_w +: cell_w] = cell_t'(val_in) + cell_t'(1);
         end
      end else if (check_flag) begin
         m_solved = (m_user == m_real);
      end else if (try_again_flag) begin
         for (int i = 0; i < num_cells; i++) begin
            if (!m_fill[i]) begin
               m_user[i*cell_w +: cell_w] = '0;
            end
         end
      end
   endtask

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   task automatic clock_and_check();
      update_model();
      next_cycle();
      check_board("user_board", user_board, m_user);
      check_board("real_board", real_board, m_real);
      check_mask("fill_flag", fill_flag, m_fill);
      check_bit("solved", solved, m_solved);
      restart        = 1'b0;
      win_flag       = 1'b0;
      set_board_flag = 1'b0;
      set_diff_flag  = 1'b0;
      insert_flag    = 1'b0;
      check_flag     = 1'b0;
      try_again_flag = 1'b0;
   endtask

   task automatic load_board();
      set_board_flag = 1'b1;
      rand_a = rand_t'($urandom);
      rand_b = rand_t'($urandom);
      clock_and_check();
   endtask

   task automatic add_hints(input level_t lvl);
      set_diff_flag = 1'b1;
      difficulty = lvl;
      rand_a = rand_t'($urandom);
      rand_b = rand_t'($urandom);
      clock_and_check();
   endtask

   task automatic insert_move(input cell_idx_t c, input entry_t v);
      insert_flag = 1'b1;
      cell_in = c;
      val_in = v;
      clock_and_check();
   endtask

   task automatic wrong_move();
      cell_idx_t c;
      c = cell_idx_t'($urandom);
      for (int n = 0; n < num_cells && m_fill[c]; n++) begin
         c = c + cell_idx_t'(1);
      end
      insert_move(c, entry_t'(m_real[int'(c)*cell_w +: cell_w] - 3'd1
                              + cell_t'($urandom_range(1, 3))));
   endtask

   task automatic random_strobes();
      restart        = ($urandom_range(0, 39) == 0);
      win_flag       = ($urandom_range(0, 59) == 0);
      set_board_flag = ($urandom_range(0, 7) == 0);
      set_diff_flag  = ($urandom_range(0, 3) == 0);
      insert_flag    = ($urandom_range(0, 1) == 0);
      check_flag     = ($urandom_range(0, 3) == 0);
      try_again_flag = ($urandom_range(0, 5) == 0);
      rand_a     = rand_t'($urandom);
      rand_b     = rand_t'($urandom);
      difficulty = level_t'($urandom_range(0, 3));
      cell_in    = cell_idx_t'($urandom);
      val_in     = entry_t'($urandom);
      // givens present, so a reload must keep the same solution
      if (m_fill != '0) begin
         if (key_loaded) begin
            rand_a[1:0] = key_ra[1:0];
            rand_b[0]   = key_rb[0];
         end else begin
            set_board_flag = 1'b0;
         end
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      void'($urandom(32'hb01e));
      rst = 1'b1;
      restart = 1'b0;
      win_flag = 1'b0;
      set_board_flag = 1'b0;
      set_diff_flag = 1'b0;
      insert_flag = 1'b0;
      check_flag = 1'b0;
      try_again_flag = 1'b0;
      rand_a = '0;
      rand_b = '0;
      difficulty = lvl_none;
      cell_in = '0;
      val_in = '0;
      key_ra = '0;
      key_rb = '0;
      repeat (16) clock_and_check();
      rst = 1'b0;

      // clears from restart and win
      repeat (10) begin
         load_board();
         add_hints(level_t'($urandom_range(0, 3)));
         insert_move(cell_idx_t'($urandom), entry_t'($urandom));
         if ($urandom_range(0, 1) == 0) restart = 1'b1;
         else win_flag = 1'b1;
         clock_and_check();
      end

      // solution boards
      repeat (16) load_board();

      // hints at every level, twice to accumulate
      for (int lvl = 0; lvl < 4; lvl++) begin
         restart = 1'b1;
         clock_and_check();
         load_board();
         add_hints(level_t'(lvl));
         add_hints(level_t'(lvl));
      end

      // random moves
      restart = 1'b1;
      clock_and_check();
      load_board();
      add_hints(lvl_medium);
      repeat (40) insert_move(cell_idx_t'($urandom), entry_t'($urandom));

      // solve from the model board, then break it
      restart = 1'b1;
      clock_and_check();
      load_board();
      add_hints(lvl_hard);
      for (int i = 0; i < num_cells; i++) begin
         if (!m_fill[i]) begin
            insert_move(cell_idx_t'(i), entry_t'(m_real[i*cell_w +: cell_w] - 3'd1));
         end
      end
      check_flag = 1'b1;
      clock_and_check();
      check_bit("solved", solved, 1'b1);
      wrong_move();
      check_flag = 1'b1;
      clock_and_check();
      check_bit("solved", solved, 1'b0);
      try_again_flag = 1'b1;
      clock_and_check();

      // mixed strobes under the priority order
      repeat (400) begin
         random_strobes();
         clock_and_check();
      end

      $display("** PASS **");
      $finish;
   end

   initial begin
      #run_limit_ns;
      $display("simulation ran past its time limit");
      stop_failed();
   end

endmodule

`default_nettype wire

// File: all.f
hdl/board_pkg.sv
hdl/level_pkg.sv
hdl/solution_key.sv
hdl/hint_select.sv
hdl/player_board.sv
hdl/sudoku_top.sv
tb/tb_clock.sv
tb/sudoku_checker.sv
tb/tb_sudoku.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timing --assert --timescale 1ns/1ps
TOP       := tb_sudoku
FILELIST  := all.f
BUILD_DIR := obj_dir

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
